//--- Makefile
# Verilator build and run for the endpoint 0 control subsystem

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module usbCtrlEpTb -f usb_ctrl_ep.f
	./obj_dir/VusbCtrlEpTb | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

//--- bench/usbCtrlEpProperties.sv
`timescale 1ns/1ps
`default_nettype none

module usbCtrlEpProperties (
    input logic clk48_i,
    input logic rst_i,
    input logic usbResetDetected_i,
    input logic usbResetAck_i,
    input logic reqError_i,
    input logic dataAvailable_i,
    input logic isLastByte_i
);

    // Last-byte flag only on a byte that is really there
    lastByteHasData: assert property (@(posedge clk48_i) disable iff (rst_i)
        isLastByte_i |-> dataAvailable_i)
        else $error("outIsLastByte_o high while outDataAvailable_o is low");

    // One strobe per decoded request
    reqErrorOneCycle: assert property (@(posedge clk48_i) disable iff (rst_i)
        reqError_i |=> !reqError_i)
        else $error("reqError_o high for two cycles in a row");

    resetAckFollows: assert property (@(posedge clk48_i) disable iff (rst_i)
        usbResetDetected_i |=> usbResetAck_i)
        else $error("usbResetAck_o did not follow usbResetDetected_i");

endmodule

bind usbCtrlEpTop usbCtrlEpProperties u_props (
    .clk48_i(clk48_i),
    .rst_i(rst_i),
    .usbResetDetected_i(usbResetDetected_i),
    .usbResetAck_i(usbResetAck_o),
    .reqError_i(reqError_o),
    .dataAvailable_i(outDataAvailable_o),
    .isLastByte_i(outIsLastByte_o)
);

`default_nettype wire

//--- bench/usbCtrlEpTb.sv
`timescale 1ns/1ps
`default_nettype none

module usbCtrlEpTb;
    import usbEp0Pkg::*;

    typedef logic [7:0] ByteList [$];

    localparam int DATA_TIMEOUT = 20;
    localparam int COMPARE_TIMEOUT = 400;

    logic clk48_i;
    logic rst_i;
    logic usbResetDetected_i;
    logic usbResetAck_o;
    logic [DEV_ADDR_WID-1:0] deviceAddr_o;
    logic [DEV_CONF_WID-1:0] deviceConf_o;
    logic gotTransStartPacket_i;
    PidType transStartPid_i;
    logic setupFillDone_i;
    logic setupFillSuccess_i;
    logic setupDataValid_i;
    logic [7:0] setupData_i;
    logic setupFull_o;
    logic outPopDone_i;
    logic outPopSuccess_i;
    logic outPop_i;
    logic outDataAvailable_o;
    logic outIsLastByte_o;
    logic [7:0] outData_o;
    logic reqError_o;

    string curName;
    int testCount;
    int checkCount;
    int errorCount;
    int errAtStart;
    ByteList expQ;
    bit compareReplay;
    bit compareGo;

    usbCtrlEpTop u_dut (.*);

    always #10 clk48_i = ~clk48_i;

    // Standard SETUP layout, first byte in the low bits
    function automatic logic [63:0] setupPacket(input logic [7:0] reqType,
            input logic [7:0] request, input logic [15:0] value,
            input logic [15:0] index, input logic [15:0] length);
        return {length, index, value, request, reqType};
    endfunction

    // Expected reply bytes of an accepted request
    function automatic ByteList expectedReply(input logic [63:0] pkt, input logic [7:0] conf);
        ByteList bytes;
        logic [7:0] descType;
        int base;
        int limit;
        int len;
        int i;
        descType = pkt[31:24];
        len = int'(pkt[63:48]);
        bytes = {};
        if (pkt[15:8] == GET_CONFIGURATION) begin
            bytes.push_back(conf);
        end else if (pkt[15:8] == GET_DESCRIPTOR) begin
            base = (descType == DESC_TYPE_CONFIG) ? int'(CONF_DESC_OFFSET) : 0;
            limit = int'((descType == DESC_TYPE_CONFIG) ? CONF_DESC_LEN : DEV_DESC_LEN);
            if (len > limit) begin
                len = limit;
            end
            for (i = 0; i < len; i++) begin
                bytes.push_back(DESC_ROM[base + i]);
            end
        end
        return bytes;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h",
                     curName, what, expected, actual);
        end
    endtask

    task automatic startTest(input string name);
        curName = name;
        errAtStart = errorCount;
    endtask

    task automatic endTest();
        testCount++;
        if (errorCount == errAtStart) begin
            $display("PASS %s", curName);
        end else begin
            $display("FAIL %s with %0d errors", curName, errorCount - errAtStart);
        end
    endtask

    // Token, data bytes, then the done strobe
    task automatic sendSetup(input logic [63:0] pkt, input int byteCount, input bit fillOk);
        int i;
        @(posedge clk48_i);
        gotTransStartPacket_i <= 1'b1;
        transStartPid_i <= PID_SETUP;
        for (i = 0; i < byteCount; i++) begin
            @(posedge clk48_i);
            gotTransStartPacket_i <= 1'b0;
            setupDataValid_i <= 1'b1;
            setupData_i <= pkt[8*i +: 8];
        end
        @(posedge clk48_i);
        gotTransStartPacket_i <= 1'b0;
        setupDataValid_i <= 1'b0;
        setupFillDone_i <= 1'b1;
        setupFillSuccess_i <= fillOk;
        @(posedge clk48_i);
        setupFillDone_i <= 1'b0;
        setupFillSuccess_i <= 1'b0;
    endtask

    task automatic sendToken();
        @(posedge clk48_i);
        gotTransStartPacket_i <= 1'b1;
        transStartPid_i <= PID_SETUP;
        @(posedge clk48_i);
        gotTransStartPacket_i <= 1'b0;
    endtask

    task automatic pulseBusReset();
        @(posedge clk48_i);
        usbResetDetected_i <= 1'b1;
        @(posedge clk48_i);
        usbResetDetected_i <= 1'b0;
    endtask

    task automatic popOnce();
        @(posedge clk48_i);
        outPop_i <= 1'b1;
        @(posedge clk48_i);
        outPop_i <= 1'b0;
    endtask

    task automatic finishTransfer(input bit ok);
        @(posedge clk48_i);
        outPopDone_i <= 1'b1;
        outPopSuccess_i <= ok;
        @(posedge clk48_i);
        outPopDone_i <= 1'b0;
        outPopSuccess_i <= 1'b0;
    endtask

    task automatic expectError(input bit expected);
        @(negedge clk48_i);
        checkValue("reqError", expected, reqError_o);
    endtask

    task automatic checkDevice(input logic [6:0] addr, input logic [7:0] conf);
        checkValue("deviceAddr", addr, deviceAddr_o);
        checkValue("deviceConf", conf, deviceConf_o);
    endtask

    // Called on a falling edge
    task automatic waitForData();
        int t;
        for (t = 0; t < DATA_TIMEOUT && !outDataAvailable_o; t++) begin
            @(negedge clk48_i);
        end
        if (!outDataAvailable_o) begin
            errorCount++;
            $display("Timed out in %s waiting for reply data", curName);
        end
    endtask

    task automatic compareReply();
        int pass;
        int i;
        for (pass = 0; pass < (compareReplay ? 2 : 1); pass++) begin
            if (expQ.size() > 0) begin
                waitForData();
            end
            for (i = 0; i < expQ.size(); i++) begin
                checkValue($sformatf("byte %0d", i), expQ[i], outData_o);
                checkValue($sformatf("last flag %0d", i), i == expQ.size() - 1,
                           outIsLastByte_o);
                popOnce();
                @(negedge clk48_i);
            end
            checkValue("outDataAvailable after last byte", 0, outDataAvailable_o);
            // A failed first pass rewinds the reply
            finishTransfer(pass == 1 || !compareReplay);
            @(negedge clk48_i);
        end
        checkValue("outDataAvailable after done", 0, outDataAvailable_o);
    endtask

    task automatic runCompare(input logic [63:0] pkt, input logic [7:0] conf, input bit replay);
        int t;
        expQ = expectedReply(pkt, conf);
        compareReplay = replay;
        compareGo = 1'b1;
        for (t = 0; t < COMPARE_TIMEOUT && compareGo; t++) begin
            @(negedge clk48_i);
        end
        if (compareGo) begin
            errorCount++;
            $display("Reply comparison in %s did not finish in time", curName);
        end
    endtask

    // Reply checker, armed by the main sequence
    initial begin
        forever begin
            @(negedge clk48_i);
            if (compareGo) begin
                compareReply();
                compareGo = 1'b0;
            end
        end
    end

    initial begin
        logic [63:0] pkt;
        logic [6:0] addr;
        logic [15:0] len;
        int d;
        clk48_i = 1'b0;
        rst_i = 1'b1;
        usbResetDetected_i = 1'b0;
        gotTransStartPacket_i = 1'b0;
        transStartPid_i = PID_SETUP;
        setupFillDone_i = 1'b0;
        setupFillSuccess_i = 1'b0;
        setupDataValid_i = 1'b0;
        setupData_i = 8'h00;
        outPopDone_i = 1'b0;
        outPopSuccess_i = 1'b0;
        outPop_i = 1'b0;
        testCount = 0;
        checkCount = 0;
        errorCount = 0;
        compareGo = 1'b0;
        compareReplay = 1'b0;
        void'($urandom(32'he5f0_78bd));
        repeat (2) @(posedge clk48_i);
        rst_i <= 1'b0;

        startTest("resetDefaults");
        @(negedge clk48_i);
        checkDevice(7'd0, 8'd0);
        checkValue("reqError", 0, reqError_o);
        checkValue("outDataAvailable", 0, outDataAvailable_o);
        checkValue("usbResetAck", 0, usbResetAck_o);
        checkValue("setupFull", 0, setupFull_o);
        // No bus reset yet, so even a valid request fails
        sendSetup(setupPacket(8'h00, SET_ADDRESS, 16'd5, 16'd0, 16'd0), 8, 1'b1);
        expectError(1'b1);
        checkDevice(7'd0, 8'd0);
        endTest();

        startTest("busReset");
        pulseBusReset();
        @(negedge clk48_i);
        checkValue("usbResetAck", 1, usbResetAck_o);
        addr = 7'($urandom_range(127, 1));
        sendSetup(setupPacket(8'h00, SET_ADDRESS, 16'(addr), 16'd0, 16'd0), 8, 1'b1);
        expectError(1'b0);
        checkDevice(addr, 8'd0);
        checkValue("usbResetAck", 0, usbResetAck_o);
        sendSetup(setupPacket(8'h00, SET_ADDRESS, 16'd0, 16'd0, 16'd0), 8, 1'b1);
        expectError(1'b0);
        checkDevice(7'd0, 8'd0);
        checkValue("usbResetAck", 1, usbResetAck_o);
        sendSetup(setupPacket(8'h80, GET_CONFIGURATION, 16'd0, 16'd0, 16'd1), 8, 1'b1);
        expectError(1'b1);
        endTest();

        startTest("getDescriptor");
        for (d = 0; d < 4; d++) begin
            len = (d < 2) ? 16'd64 : 16'($urandom_range(64, 0));
            pkt = setupPacket(8'h80, GET_DESCRIPTOR,
                              {(d % 2 == 0) ? DESC_TYPE_DEVICE : DESC_TYPE_CONFIG, 8'h00},
                              16'd0, len);
            sendSetup(pkt, 8, 1'b1);
            expectError(1'b0);
            runCompare(pkt, 8'h00, 1'b1);
        end
        endTest();

        startTest("configuration");
        sendSetup(setupPacket(8'h00, SET_ADDRESS, 16'h002a, 16'd0, 16'd0), 8, 1'b1);
        expectError(1'b0);
        sendSetup(setupPacket(8'h00, SET_CONFIGURATION, 16'd1, 16'd0, 16'd0), 8, 1'b1);
        expectError(1'b0);
        checkDevice(7'h2a, 8'd1);
        pkt = setupPacket(8'h80, GET_CONFIGURATION, 16'd0, 16'd0, 16'd1);
        sendSetup(pkt, 8, 1'b1);
        expectError(1'b0);
        runCompare(pkt, 8'd1, 1'b0);
        sendSetup(setupPacket(8'h00, SET_CONFIGURATION, 16'd2, 16'd0, 16'd0), 8, 1'b1);
        expectError(1'b1);
        checkDevice(7'h2a, 8'd1);
        sendSetup(setupPacket(8'h00, SET_CONFIGURATION, 16'd0, 16'd0, 16'd0), 8, 1'b1);
        expectError(1'b0);
        checkDevice(7'h2a, 8'd0);
        endTest();

        startTest("badRequests");
        sendSetup(setupPacket(8'h00, GET_DESCRIPTOR, 16'h0100, 16'd0, 16'd18), 8, 1'b1);
        expectError(1'b1);
        checkDevice(7'h2a, 8'd0);
        sendSetup(setupPacket(8'h80, GET_STATUS, 16'd0, 16'd0, 16'd2), 8, 1'b1);
        expectError(1'b1);
        checkDevice(7'h2a, 8'd0);
        sendSetup(setupPacket(8'h80, GET_DESCRIPTOR, 16'h0300, 16'd0, 16'd18), 8, 1'b1);
        expectError(1'b1);
        checkDevice(7'h2a, 8'd0);
        // Failed fill and short packet are both ignored
        pkt = setupPacket(8'h80, GET_DESCRIPTOR, 16'h0100, 16'd0, 16'd18);
        sendSetup(pkt, 8, 1'b0);
        expectError(1'b0);
        checkValue("outDataAvailable", 0, outDataAvailable_o);
        sendSetup(pkt, 5, 1'b1);
        expectError(1'b0);
        checkValue("outDataAvailable", 0, outDataAvailable_o);
        endTest();

        startTest("cancelReply");
        pkt = setupPacket(8'h80, GET_DESCRIPTOR, {DESC_TYPE_DEVICE, 8'h00}, 16'd0, 16'd18);
        sendSetup(pkt, 8, 1'b1);
        @(negedge clk48_i);
        waitForData();
        popOnce();
        popOnce();
        @(negedge clk48_i);
        checkValue("outDataAvailable mid reply", 1, outDataAvailable_o);
        sendToken();
        @(negedge clk48_i);
        checkValue("outDataAvailable after SETUP", 0, outDataAvailable_o);
        pkt = setupPacket(8'h80, GET_DESCRIPTOR, {DESC_TYPE_CONFIG, 8'h00}, 16'd0, 16'd9);
        sendSetup(pkt, 8, 1'b1);
        expectError(1'b0);
        runCompare(pkt, 8'h00, 1'b0);
        endTest();

        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/setupPacketBuf.sv
`timescale 1ns/1ps
`default_nettype none

module setupPacketBuf (
    input logic clk48_i,
    input logic rst_i,
    input logic clear_i,
    input logic dataValid_i,
    input logic [7:0] data_i,
    output logic [usbEp0Pkg::SETUP_BYTE_COUNT*8-1:0] buffer_o,
    output logic full_o
);
    import usbEp0Pkg::*;

    localparam int COUNT_WID = $clog2(SETUP_BYTE_COUNT + 1);

    logic [COUNT_WID-1:0] byteCount;

    assign full_o = byteCount == COUNT_WID'(SETUP_BYTE_COUNT);

    always_ff @(posedge clk48_i) begin
        if (rst_i || clear_i) begin
            byteCount <= '0;
        end else if (dataValid_i && !full_o) begin
            byteCount <= byteCount + 1'b1;
        end
    end

    // Shift from the top so the first byte ends up at the low end
    always_ff @(posedge clk48_i) begin
        if (dataValid_i && !full_o) begin
            buffer_o <= {data_i, buffer_o[SETUP_BYTE_COUNT*8-1:8]};
        end
    end

endmodule

`default_nettype wire

//--- hw/usbCtrlEpTop.sv
`timescale 1ns/1ps
`default_nettype none

module usbCtrlEpTop (
    input logic clk48_i,
    input logic rst_i,
    input logic usbResetDetected_i,
    output logic usbResetAck_o,
    output logic [usbEp0Pkg::DEV_ADDR_WID-1:0] deviceAddr_o,
    output logic [usbEp0Pkg::DEV_CONF_WID-1:0] deviceConf_o,
    input logic gotTransStartPacket_i,
    input usbEp0Pkg::PidType transStartPid_i,
    input logic setupFillDone_i,
    input logic setupFillSuccess_i,
    input logic setupDataValid_i,
    input logic [7:0] setupData_i,
    output logic setupFull_o,
    input logic outPopDone_i,
    input logic outPopSuccess_i,
    input logic outPop_i,
    output logic outDataAvailable_o,
    output logic outIsLastByte_o,
    output logic [7:0] outData_o,
    output logic reqError_o
);
    import usbEp0Pkg::*;

    logic bufClear;
    logic [SETUP_BYTE_COUNT*8-1:0] setupWord;
    DeviceState deviceState;
    logic setAddr;
    logic setConf;
    logic [7:0] reqValue;
    logic replyStart;
    logic [ROM_ADDR_WID-1:0] replyOffset;
    logic [REPLY_LEN_WID-1:0] replyLength;
    ReplySource replySource;
    logic replyCancel;

    // Each token or finished packet starts a fresh buffer
    assign bufClear = gotTransStartPacket_i || setupFillDone_i;

    setupPacketBuf u_setupBuf (
        .clk48_i(clk48_i),
        .rst_i(rst_i),
        .clear_i(bufClear),
        .dataValid_i(setupDataValid_i),
        .data_i(setupData_i),
        .buffer_o(setupWord),
        .full_o(setupFull_o)
    );

    usbEndpoint0 u_ep0 (
        .clk48_i(clk48_i),
        .rst_i(rst_i),
        .gotTransStartPacket_i(gotTransStartPacket_i),
        .transStartPid_i(transStartPid_i),
        .fillDone_i(setupFillDone_i),
        .fillSuccess_i(setupFillSuccess_i),
        .setupWord_i(setupWord),
        .setupFull_i(setupFull_o),
        .devState_i(deviceState),
        .setAddr_o(setAddr),
        .setConf_o(setConf),
        .reqValue_o(reqValue),
        .replyStart_o(replyStart),
        .replyOffset_o(replyOffset),
        .replyLength_o(replyLength),
        .replySource_o(replySource),
        .replyCancel_o(replyCancel),
        .reqError_o(reqError_o)
    );

    usbDeviceState u_devState (
        .clk48_i(clk48_i),
        .rst_i(rst_i),
        .usbResetDetected_i(usbResetDetected_i),
        .setAddr_i(setAddr),
        .setConf_i(setConf),
        .reqValue_i(reqValue),
        .state_o(deviceState),
        .deviceAddr_o(deviceAddr_o),
        .deviceConf_o(deviceConf_o),
        .usbResetAck_o(usbResetAck_o)
    );

    usbDescStreamer u_streamer (
        .clk48_i(clk48_i),
        .rst_i(rst_i),
        .start_i(replyStart),
        .offset_i(replyOffset),
        .length_i(replyLength),
        .source_i(replySource),
        .confValue_i(deviceConf_o),
        .cancel_i(replyCancel),
        .pop_i(outPop_i),
        .popDone_i(outPopDone_i),
        .popSuccess_i(outPopSuccess_i),
        .dataAvailable_o(outDataAvailable_o),
        .data_o(outData_o),
        .isLastByte_o(outIsLastByte_o)
    );

endmodule

`default_nettype wire

//--- hw/usbDescStreamer.sv
`timescale 1ns/1ps
`default_nettype none

module usbDescStreamer (
    input logic clk48_i,
    input logic rst_i,
    input logic start_i,
    input logic [usbEp0Pkg::ROM_ADDR_WID-1:0] offset_i,
    input logic [usbEp0Pkg::REPLY_LEN_WID-1:0] length_i,
    input usbEp0Pkg::ReplySource source_i,
    input logic [usbEp0Pkg::DEV_CONF_WID-1:0] confValue_i,
    input logic cancel_i,
    input logic pop_i,
    input logic popDone_i,
    input logic popSuccess_i,
    output logic dataAvailable_o,
    output logic [7:0] data_o,
    output logic isLastByte_o
);
    import usbEp0Pkg::*;

    logic active;
    ReplySource source;
    logic [ROM_ADDR_WID-1:0] startOffset;
    logic [REPLY_LEN_WID-1:0] byteCount;
    logic [REPLY_LEN_WID-1:0] readPtr;
    logic [ROM_ADDR_WID-1:0] romAddr;
    logic [7:0] romByte;

    assign romAddr = startOffset + readPtr[ROM_ADDR_WID-1:0];
    assign romByte = (int'(romAddr) < DESC_ROM_SIZE) ? DESC_ROM[romAddr] : 8'h00;

    assign dataAvailable_o = active && (readPtr != byteCount);
    assign isLastByte_o = active && (REPLY_LEN_WID'(readPtr + 1'b1) == byteCount);

    always_comb begin
        if (source == CONFIG_VALUE) begin
            data_o = 8'(confValue_i);
        end else begin
            data_o = romByte;
        end
    end

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            active <= 1'b0;
            readPtr <= '0;
        end else if (start_i) begin
            active <= 1'b1;
            readPtr <= '0;
        end else if (cancel_i) begin
            active <= 1'b0;
        end else if (active) begin
            if (popDone_i) begin
                // Failed transaction replays the reply from its first byte
                if (popSuccess_i) begin
                    active <= 1'b0;
                end else begin
                    readPtr <= '0;
                end
            end else if (pop_i && dataAvailable_o) begin
                readPtr <= readPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk48_i) begin
        if (start_i) begin
            startOffset <= offset_i;
            byteCount <= length_i;
            source <= source_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/usbDeviceState.sv
`timescale 1ns/1ps
`default_nettype none

module usbDeviceState (
    input logic clk48_i,
    input logic rst_i,
    input logic usbResetDetected_i,
    input logic setAddr_i,
    input logic setConf_i,
    input logic [7:0] reqValue_i,
    output usbEp0Pkg::DeviceState state_o,
    output logic [usbEp0Pkg::DEV_ADDR_WID-1:0] deviceAddr_o,
    output logic [usbEp0Pkg::DEV_CONF_WID-1:0] deviceConf_o,
    output logic usbResetAck_o
);
    import usbEp0Pkg::*;

    logic [DEV_ADDR_WID-1:0] newAddr;
    logic [DEV_CONF_WID-1:0] newConf;

    assign newAddr = reqValue_i[DEV_ADDR_WID-1:0];
    assign newConf = reqValue_i[DEV_CONF_WID-1:0];

    // Ack stays up as long as the device sits in the default state
    assign usbResetAck_o = state_o == DEFAULT;

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            state_o <= NOT_RESET;
            deviceAddr_o <= '0;
            deviceConf_o <= '0;
        end else if (usbResetDetected_i) begin
            state_o <= DEFAULT;
            deviceAddr_o <= '0;
            deviceConf_o <= '0;
        end else if (setAddr_i) begin
            deviceAddr_o <= newAddr;
            if (newAddr == '0) begin
                state_o <= DEFAULT;
            end else begin
                state_o <= ADDRESSED;
            end
        end else if (setConf_i) begin
            deviceConf_o <= newConf;
            // Configuration 0 drops back to addressed
            if (newConf == '0) begin
                state_o <= ADDRESSED;
            end else begin
                state_o <= CONFIGURED;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/usbEndpoint0.sv
`timescale 1ns/1ps
`default_nettype none

module usbEndpoint0 (
    input logic clk48_i,
    input logic rst_i,
    input logic gotTransStartPacket_i,
    input usbEp0Pkg::PidType transStartPid_i,
    input logic fillDone_i,
    input logic fillSuccess_i,
    input logic [usbEp0Pkg::SETUP_BYTE_COUNT*8-1:0] setupWord_i,
    input logic setupFull_i,
    input usbEp0Pkg::DeviceState devState_i,
    output logic setAddr_o,
    output logic setConf_o,
    output logic [7:0] reqValue_o,
    output logic replyStart_o,
    output logic [usbEp0Pkg::ROM_ADDR_WID-1:0] replyOffset_o,
    output logic [usbEp0Pkg::REPLY_LEN_WID-1:0] replyLength_o,
    output usbEp0Pkg::ReplySource replySource_o,
    output logic replyCancel_o,
    output logic reqError_o
);
    import usbEp0Pkg::*;

    logic expectReq;
    logic gotSetup;
    logic decodeNow;
    logic reqErrorNext;
    logic stateHasAddr;
    logic [7:0] reqType;
    logic [7:0] reqCode;
    SetupValue value;
    logic [15:0] wIndex;
    logic [15:0] wLength;
    logic [REPLY_LEN_WID-1:0] descLen;

    // Standard SETUP layout, little endian fields
    assign reqType = setupWord_i[7:0];
    assign reqCode = setupWord_i[15:8];
    assign value = setupWord_i[31:16];
    assign wIndex = setupWord_i[47:32];
    assign wLength = setupWord_i[63:48];

    assign reqValue_o = value.addrView[7:0];

    assign gotSetup = gotTransStartPacket_i && transStartPid_i == PID_SETUP;
    assign replyCancel_o = gotSetup;
    assign decodeNow = expectReq && fillDone_i && fillSuccess_i && setupFull_i;
    assign stateHasAddr = devState_i == ADDRESSED || devState_i == CONFIGURED;

    assign descLen = (value.descView.descType == DESC_TYPE_CONFIG) ? CONF_DESC_LEN
                                                                     : DEV_DESC_LEN;

    always_comb begin
        setAddr_o = 1'b0;
        setConf_o = 1'b0;
        replyStart_o = 1'b0;
        replyOffset_o = '0;
        replyLength_o = '0;
        replySource_o = ROM;
        reqErrorNext = 1'b0;

        if (decodeNow) begin
            // Nothing is answered before the first bus reset
            reqErrorNext = 1'b1;
            if (devState_i != NOT_RESET) begin
                case (reqCode)
                    SET_ADDRESS: begin
                        if (reqType == REQ_TYPE_STD_OUT && wIndex == '0 && wLength == '0
                                && value.addrView.reserved == '0
                                && devState_i != CONFIGURED) begin
                            setAddr_o = 1'b1;
                            replyStart_o = 1'b1;
                            reqErrorNext = 1'b0;
                        end
                    end
                    SET_CONFIGURATION: begin
                        if (reqType == REQ_TYPE_STD_OUT && stateHasAddr
                                && value.addrView <= 16'(NUM_CONFIGS)) begin
                            setConf_o = 1'b1;
                            replyStart_o = 1'b1;
                            reqErrorNext = 1'b0;
                        end
                    end
                    GET_DESCRIPTOR: begin
                        if (reqType == REQ_TYPE_STD_IN && value.descView.descIndex == '0
                                && (value.descView.descType == DESC_TYPE_DEVICE
                                || value.descView.descType == DESC_TYPE_CONFIG)) begin
                            replyStart_o = 1'b1;
                            reqErrorNext = 1'b0;
                            if (value.descView.descType == DESC_TYPE_CONFIG) begin
                                replyOffset_o = CONF_DESC_OFFSET;
                            end
                            // Host may ask for fewer bytes than the descriptor holds
                            if (wLength < 16'(descLen)) begin
                                replyLength_o = wLength[REPLY_LEN_WID-1:0];
                            end else begin
                                replyLength_o = descLen;
                            end
                        end
                    end
                    GET_CONFIGURATION: begin
                        if (reqType == REQ_TYPE_STD_IN && wLength == 16'd1 && stateHasAddr) begin
                            replyStart_o = 1'b1;
                            replyLength_o = REPLY_LEN_WID'(1);
                            replySource_o = CONFIG_VALUE;
                            reqErrorNext = 1'b0;
                        end
                    end
                    default: begin
                        reqErrorNext = 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            expectReq <= 1'b0;
            reqError_o <= 1'b0;
        end else begin
            reqError_o <= reqErrorNext;
            if (gotTransStartPacket_i) begin
                expectReq <= gotSetup;
            end else if (fillDone_i) begin
                // One data packet per SETUP token
                expectReq <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/usbEp0Pkg.sv
`default_nettype none

package usbEp0Pkg;

    localparam int SETUP_BYTE_COUNT = 8;
    localparam int MAX_PACKET_SIZE0 = 64;
    localparam int DEV_ADDR_WID = 7;
    localparam int DEV_CONF_WID = 8;
    localparam int NUM_CONFIGS = 1;

    // Reply lengths up to one full packet
    localparam int REPLY_LEN_WID = $clog2(MAX_PACKET_SIZE0 + 1);

    localparam logic [REPLY_LEN_WID-1:0] DEV_DESC_LEN = 18;
    localparam logic [REPLY_LEN_WID-1:0] CONF_DESC_LEN = 18;
    localparam int DESC_ROM_SIZE = DEV_DESC_LEN + CONF_DESC_LEN;
    localparam int ROM_ADDR_WID = $clog2(DESC_ROM_SIZE);
    localparam logic [ROM_ADDR_WID-1:0] CONF_DESC_OFFSET = 18;

    localparam logic [7:0] DESC_TYPE_DEVICE = 8'd1;
    localparam logic [7:0] DESC_TYPE_CONFIG = 8'd2;

    // bmRequestType for standard device requests
    localparam logic [7:0] REQ_TYPE_STD_OUT = 8'h00;
    localparam logic [7:0] REQ_TYPE_STD_IN = 8'h80;

    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_SOF   = 4'b0101,
        PID_IN    = 4'b1001,
        PID_SETUP = 4'b1101,
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010,
        PID_STALL = 4'b1110
    } PidType;

    typedef enum logic [7:0] {
        GET_STATUS        = 8'd0,
        CLEAR_FEATURE     = 8'd1,
        RESERVED_2        = 8'd2,
        SET_FEATURE       = 8'd3,
        RESERVED_4        = 8'd4,
        SET_ADDRESS       = 8'd5,
        GET_DESCRIPTOR    = 8'd6,
        SET_DESCRIPTOR    = 8'd7,
        GET_CONFIGURATION = 8'd8,
        SET_CONFIGURATION = 8'd9,
        GET_INTERFACE     = 8'd10,
        SET_INTERFACE     = 8'd11,
        SYNCH_FRAME       = 8'd12
    } RequestCode;

    typedef enum logic [1:0] {
        NOT_RESET,
        DEFAULT,
        ADDRESSED,
        CONFIGURED
    } DeviceState;

    // wValue seen either as an address or as a descriptor selector
    typedef union packed {
        struct packed {
            logic [8:0] reserved;
            logic [DEV_ADDR_WID-1:0] addr;
        } addrView;
        struct packed {
            logic [7:0] descType;
            logic [7:0] descIndex;
        } descView;
    } SetupValue;

    typedef enum logic {
        ROM,
        CONFIG_VALUE
    } ReplySource;

    // Device descriptor, then configuration and interface descriptors
    localparam logic [7:0] DESC_ROM [0:DESC_ROM_SIZE-1] = '{
        8'd18, DESC_TYPE_DEVICE, 8'h00, 8'h02, 8'h00, 8'h00, 8'h00, 8'(MAX_PACKET_SIZE0),
        8'h34, 8'h12, 8'h78, 8'h56, 8'h00, 8'h01, 8'h00, 8'h00, 8'h00, 8'(NUM_CONFIGS),
        8'd9, DESC_TYPE_CONFIG, 8'(CONF_DESC_LEN), 8'h00, 8'd1, 8'd1, 8'h00, 8'h80, 8'd50,
        8'd9, 8'd4, 8'h00, 8'h00, 8'h00, 8'hff, 8'h00, 8'h00, 8'h00
    };

endpackage

`default_nettype wire

//--- usb_ctrl_ep.f
hw/usbEp0Pkg.sv
hw/setupPacketBuf.sv
hw/usbDeviceState.sv
hw/usbDescStreamer.sv
hw/usbEndpoint0.sv
hw/usbCtrlEpTop.sv
bench/usbCtrlEpProperties.sv
bench/usbCtrlEpTb.sv
